// File: eth_mon_consts.svh
`ifndef ETH_MON_CONSTS_SVH
`define ETH_MON_CONSTS_SVH

// Avalon-ST beat geometry, 8 byte symbols per beat
`define ETH_MON_SYMBOL_W 8
`define ETH_MON_NUM_SYMBOLS 8
`define ETH_MON_DATA_W (`ETH_MON_SYMBOL_W * `ETH_MON_NUM_SYMBOLS)
`define ETH_MON_EMPTY_W 3

// Capture buffer size in beats
`define ETH_MON_BEAT_DEPTH 64

// Record queue size in frames
`define ETH_MON_REC_DEPTH 8

// Frame length limits in bytes
`define ETH_MON_MIN_BYTES 64
`define ETH_MON_MAX_BYTES 256

// Width of byte and beat count fields
`define ETH_MON_LEN_W 12

`endif

// File: eth_mon_framer.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mon_consts.svh"

module eth_mon_framer (
    input  wire                      clk,
    input  wire                      reset,
    input  wire eth_mon_pkg::beat_t  tap_beat,
    input  wire                      tap_valid,
    input  wire                      tap_abort,
    input  wire                      beat_full,
    input  wire                      rec_room,
    output logic                     beat_wr,
    output eth_mon_pkg::beat_t       beat_wdata,
    output logic                     rec_wr,
    output eth_mon_pkg::frame_rec_t  rec_wdata,
    output logic                     frame_done,
    output logic                     frame_dropped,
    output eth_mon_pkg::frame_rec_t  frame_rec
);

    localparam int LW = `ETH_MON_LEN_W;

    // Open frame state
    logic          discard;
    logic          after_abort;
    logic [LW-1:0] acc_len;
    logic [LW-1:0] acc_beats;
    logic          acc_err;
    logic          acc_trunc;

    // Per cycle decode
    logic          start;
    logic          abort_rec;
    logic          abort_drop;
    logic          new_discard;
    logic          store;
    logic          lost;
    logic          close_rec;
    logic          close_drop;
    logic [LW-1:0] beat_bytes;
    logic [LW-1:0] cur_len;
    logic [LW-1:0] cur_beats;
    logic          cur_err;
    logic          cur_trunc;

    function automatic logic [LW-1:0] sat_add(input logic [LW-1:0] a, input logic [LW-1:0] b);
        logic [LW:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[LW] ? '1 : sum[LW-1:0];
    endfunction

    // Length limits are applied when the record is built
    function automatic eth_mon_pkg::frame_rec_t make_rec(input logic [LW-1:0] len,
        input logic [LW-1:0] beats, input logic err, input logic trunc, input logic aborted);
        eth_mon_pkg::frame_rec_t r;
        r.length_bytes = len;
        r.stored_beats = beats;
        r.error        = err;
        r.runt         = len < LW'(`ETH_MON_MIN_BYTES);
        r.oversize     = len > LW'(`ETH_MON_MAX_BYTES);
        r.truncated    = trunc;
        r.aborted      = aborted;
        return r;
    endfunction

    assign start      = tap_valid && tap_beat.sop;
    assign abort_rec  = tap_abort && !discard;
    assign abort_drop = tap_abort && discard;

    // Room is checked once per frame at its start
    // a one-beat frame next to an aborted record would need a second write
    assign new_discard = start ? (!rec_room || (abort_rec && tap_beat.eop)) : discard;

    assign store = tap_valid && !new_discard && !beat_full;
    assign lost  = tap_valid && !new_discard && beat_full;

    // Empty symbols only count on the end beat
    assign beat_bytes = tap_beat.eop ? LW'(`ETH_MON_NUM_SYMBOLS) - LW'(tap_beat.empty)
                                     : LW'(`ETH_MON_NUM_SYMBOLS);

    assign cur_len   = sat_add(start ? '0 : acc_len, beat_bytes);
    assign cur_beats = sat_add(start ? '0 : acc_beats, LW'(store));
    assign cur_err   = (!start && acc_err) || tap_beat.error;
    assign cur_trunc = (!start && acc_trunc) || lost;

    assign close_rec  = tap_valid && tap_beat.eop && !new_discard;
    assign close_drop = (tap_valid && tap_beat.eop && new_discard) || abort_drop;

    assign beat_wr    = store;
    assign beat_wdata = tap_beat;

    // Aborted and normal closes never fall in the same cycle
    assign rec_wr    = abort_rec || close_rec;
    assign rec_wdata = abort_rec ? make_rec(acc_len, acc_beats, acc_err, acc_trunc, 1'b1)
                                 : make_rec(cur_len, cur_beats, cur_err, cur_trunc, 1'b0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            discard       <= 1'b0;
            after_abort   <= 1'b0;
            acc_len       <= '0;
            acc_beats     <= '0;
            acc_err       <= 1'b0;
            acc_trunc     <= 1'b0;
            frame_done    <= 1'b0;
            frame_dropped <= 1'b0;
        end else begin
            frame_done    <= rec_wr;
            frame_dropped <= close_drop;
            if (tap_valid) begin
                discard   <= new_discard;
                acc_len   <= cur_len;
                acc_beats <= cur_beats;
                acc_err   <= cur_err;
                acc_trunc <= cur_trunc;
                // Frame uses the spare record slot
                if (start) begin
                    after_abort <= abort_rec && !new_discard;
                end
            end
        end
    end

    // Copy of the record for the statistics block
    always_ff @(posedge clk) begin
        frame_rec <= rec_wdata;
    end

    // Only a frame that followed an aborted record may take the last slot
    a_rec_room: assert property (@(posedge clk) disable iff (reset)
        rec_wr |-> rec_room || after_abort)
        else $error("record write without room");

endmodule

`default_nettype wire

// File: eth_mon_pkg.sv
`default_nettype none

`include "eth_mon_consts.svh"

package eth_mon_pkg;

    // One beat as seen on the tapped stream
    typedef struct packed {
        logic [`ETH_MON_DATA_W-1:0]  data;
        logic [`ETH_MON_EMPTY_W-1:0] empty;
        logic                        sop;
        logic                        eop;
        logic                        error;
    } beat_t;

    // Descriptor written once per closed frame
    typedef struct packed {
        logic [`ETH_MON_LEN_W-1:0] length_bytes;
        // Beats of this frame actually kept in the capture buffer
        logic [`ETH_MON_LEN_W-1:0] stored_beats;
        logic                      error;
        logic                      runt;
        logic                      oversize;
        logic                      truncated;
        logic                      aborted;
    } frame_rec_t;

    // Running statistics, all saturating
    typedef struct packed {
        logic [15:0] good_frames;
        logic [15:0] error_frames;
        logic [15:0] runt_frames;
        logic [15:0] oversize_frames;
        logic [15:0] aborted_frames;
        logic [15:0] dropped_frames;
        logic [15:0] stray_beats;
        logic [31:0] total_bytes;
    } stats_t;

endpackage

`default_nettype wire

// File: eth_mon_queue.sv
`timescale 1ns/1ns
`default_nettype none

module eth_mon_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  wire            clk,
    input  wire            reset,
    input  wire            wr,
    input  wire payload_t  wdata,
    output logic           full,
    output logic           room,
    input  wire            pop,
    output payload_t       rdata,
    output logic           avail
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_pop;

    // Pop only counts while the head is valid
    assign do_pop = pop && avail;
    assign do_wr  = wr && !full;

    assign avail = count != '0;
    assign full  = count == CNT_W'(DEPTH);
    // Free entry left over besides the one a write would take
    assign room  = count < CNT_W'(DEPTH - 1);

    // Head falls through to the read side
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> avail)
        else $error("pop while empty");

    a_no_wr_full: assert property (@(posedge clk) disable iff (reset) wr |-> !full)
        else $error("write while full");

endmodule

`default_nettype wire

// File: eth_mon_stats.sv
`timescale 1ns/1ns
`default_nettype none

module eth_mon_stats (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           frame_done,
    input  wire eth_mon_pkg::frame_rec_t  frame_rec,
    input  wire                           frame_dropped,
    input  wire                           tap_stray,
    output eth_mon_pkg::stats_t           stats
);

    // Byte count of the closed frame, widened to the total
    logic [31:0] frame_bytes;

    assign frame_bytes = 32'(frame_rec.length_bytes);

    // Counters stick at all ones
    function automatic logic [15:0] inc16(input logic [15:0] v);
        return (v == '1) ? v : v + 16'd1;
    endfunction

    function automatic logic [31:0] add32(input logic [31:0] a, input logic [31:0] b);
        logic [32:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[32] ? '1 : sum[31:0];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stats <= '0;
        end else begin
            if (frame_done) begin
                stats.total_bytes <= add32(stats.total_bytes, frame_bytes);
                // One category per frame, first match wins
                if (frame_rec.aborted) begin
                    stats.aborted_frames <= inc16(stats.aborted_frames);
                end else if (frame_rec.error) begin
                    stats.error_frames <= inc16(stats.error_frames);
                end else if (frame_rec.oversize) begin
                    stats.oversize_frames <= inc16(stats.oversize_frames);
                end else if (frame_rec.runt) begin
                    stats.runt_frames <= inc16(stats.runt_frames);
                end else begin
                    stats.good_frames <= inc16(stats.good_frames);
                end
            end
            // Frame that found no record slot
            if (frame_dropped) begin
                stats.dropped_frames <= inc16(stats.dropped_frames);
            end
            if (tap_stray) begin
                stats.stray_beats <= inc16(stats.stray_beats);
            end
        end
    end

endmodule

`default_nettype wire

// File: eth_mon_tap.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mon_consts.svh"

module eth_mon_tap (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         startofpacket,
    input  wire                         endofpacket,
    input  wire                         valid,
    input  wire                         ready,
    input  wire [`ETH_MON_DATA_W-1:0]   data,
    input  wire [`ETH_MON_EMPTY_W-1:0]  empty,
    input  wire                         error,
    output eth_mon_pkg::beat_t          tap_beat,
    output logic                        tap_valid,
    output logic                        tap_abort,
    output logic                        tap_stray
);

    // Packet in progress as seen on the bus
    logic in_pkt;

    // Beat accepted by the sink
    logic take;
    // Beat that belongs to a packet and goes to the framer
    logic fwd;

    assign take = valid && ready;
    assign fwd  = take && (startofpacket || in_pkt);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_pkt    <= 1'b0;
            tap_valid <= 1'b0;
            tap_abort <= 1'b0;
            tap_stray <= 1'b0;
        end else begin
            tap_valid <= fwd;
            // New start while a packet is open closes the old one
            tap_abort <= take && startofpacket && in_pkt;
            // Data outside a packet is only counted
            tap_stray <= take && !startofpacket && !in_pkt;
            if (take) begin
                if (startofpacket) begin
                    // Single beat packet never opens
                    in_pkt <= !endofpacket;
                end else if (endofpacket) begin
                    in_pkt <= 1'b0;
                end
            end
        end
    end

    // Beat payload register
    always_ff @(posedge clk) begin
        if (fwd) begin
            tap_beat.data  <= data;
            tap_beat.empty <= empty;
            tap_beat.sop   <= startofpacket;
            tap_beat.eop   <= endofpacket;
            tap_beat.error <= error;
        end
    end

    // Abort always travels with the start beat of the next frame
    a_abort_with_start: assert property (@(posedge clk) disable iff (reset)
        tap_abort |-> tap_valid && tap_beat.sop)
        else $error("tap_abort without a start beat");

endmodule

`default_nettype wire

// File: eth_mon_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mon_consts.svh"

module eth_mon_top (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         startofpacket,
    input  wire                         endofpacket,
    input  wire                         valid,
    input  wire                         ready,
    input  wire [`ETH_MON_DATA_W-1:0]   data,
    input  wire [`ETH_MON_EMPTY_W-1:0]  empty,
    input  wire                         error,
    input  wire                         beat_pop,
    output eth_mon_pkg::beat_t          beat_out,
    output logic                        beat_avail,
    input  wire                         rec_pop,
    output eth_mon_pkg::frame_rec_t     rec_out,
    output logic                        rec_avail,
    output eth_mon_pkg::stats_t         stats
);

    // Tap to framer
    eth_mon_pkg::beat_t      tap_beat;
    logic                    tap_valid;
    logic                    tap_abort;
    logic                    tap_stray;

    // Framer to the queues
    logic                    beat_wr;
    eth_mon_pkg::beat_t      beat_wdata;
    logic                    beat_full;
    logic                    rec_wr;
    eth_mon_pkg::frame_rec_t rec_wdata;
    logic                    rec_room;

    // Framer to statistics
    logic                    frame_done;
    logic                    frame_dropped;
    eth_mon_pkg::frame_rec_t frame_rec;

    eth_mon_tap u_tap (
        .clk(clk), .reset(reset),
        .startofpacket(startofpacket), .endofpacket(endofpacket),
        .valid(valid), .ready(ready), .data(data), .empty(empty), .error(error),
        .tap_beat(tap_beat), .tap_valid(tap_valid),
        .tap_abort(tap_abort), .tap_stray(tap_stray)
    );

    eth_mon_framer u_framer (
        .clk(clk), .reset(reset),
        .tap_beat(tap_beat), .tap_valid(tap_valid), .tap_abort(tap_abort),
        .beat_full(beat_full), .rec_room(rec_room),
        .beat_wr(beat_wr), .beat_wdata(beat_wdata),
        .rec_wr(rec_wr), .rec_wdata(rec_wdata),
        .frame_done(frame_done), .frame_dropped(frame_dropped), .frame_rec(frame_rec)
    );

    // Capture buffer for frame beats
    eth_mon_queue #(.payload_t(eth_mon_pkg::beat_t), .DEPTH(`ETH_MON_BEAT_DEPTH)) u_beat_q (
        .clk(clk), .reset(reset),
        .wr(beat_wr), .wdata(beat_wdata), .full(beat_full), .room(),
        .pop(beat_pop), .rdata(beat_out), .avail(beat_avail)
    );

    // Extra slot holds the record of an aborted frame
    eth_mon_queue #(.payload_t(eth_mon_pkg::frame_rec_t), .DEPTH(`ETH_MON_REC_DEPTH + 1)) u_rec_q (
        .clk(clk), .reset(reset),
        .wr(rec_wr), .wdata(rec_wdata), .full(), .room(rec_room),
        .pop(rec_pop), .rdata(rec_out), .avail(rec_avail)
    );

    eth_mon_stats u_stats (
        .clk(clk), .reset(reset),
        .frame_done(frame_done), .frame_rec(frame_rec),
        .frame_dropped(frame_dropped), .tap_stray(tap_stray),
        .stats(stats)
    );

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
eth_mon_pkg.sv
eth_mon_tap.sv
eth_mon_framer.sv
eth_mon_queue.sv
eth_mon_stats.sv
eth_mon_top.sv
tb_eth_mon.sv

// File: tb_eth_mon.sv
`timescale 1ns/1ns
`default_nettype none

`include "eth_mon_consts.svh"

module tb_eth_mon;

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         startofpacket;
    logic                         endofpacket;
    logic                         valid;
    logic                         ready;
    logic [`ETH_MON_DATA_W-1:0]   data;
    logic [`ETH_MON_EMPTY_W-1:0]  empty;
    logic                         error;
    logic                         beat_pop;
    eth_mon_pkg::beat_t           beat_out;
    logic                         beat_avail;
    logic                         rec_pop;
    eth_mon_pkg::frame_rec_t      rec_out;
    logic                         rec_avail;
    eth_mon_pkg::stats_t          stats;

    // Expected readout, in the order the monitor must produce it
    eth_mon_pkg::frame_rec_t exp_recs[$];
    eth_mon_pkg::beat_t      exp_beats[$];
    eth_mon_pkg::stats_t     exp_stats;

    string test_name;
    bit    hold;
    int    beats_left;
    int    gen_beats;
    int    checks;
    int    rec_errors;
    int    beat_errors;
    int    stat_errors;
    int    other_errors;

    eth_mon_top dut (
        .clk(clk), .reset(reset),
        .startofpacket(startofpacket), .endofpacket(endofpacket),
        .valid(valid), .ready(ready), .data(data), .empty(empty), .error(error),
        .beat_pop(beat_pop), .beat_out(beat_out), .beat_avail(beat_avail),
        .rec_pop(rec_pop), .rec_out(rec_out), .rec_avail(rec_avail),
        .stats(stats)
    );

    always #10 clk = ~clk;

    // Record expected for a closed frame
    function automatic eth_mon_pkg::frame_rec_t expect_rec(input int len, input int sent,
        input int keep, input bit err, input bit aborted);
        eth_mon_pkg::frame_rec_t r;
        r.length_bytes = `ETH_MON_LEN_W'(len);
        // keep below zero means every sent beat fits in the buffer
        r.stored_beats = `ETH_MON_LEN_W'((keep < 0) ? sent : keep);
        r.error        = err;
        r.runt         = len < `ETH_MON_MIN_BYTES;
        r.oversize     = len > `ETH_MON_MAX_BYTES;
        r.truncated    = (keep > 0) && (keep < sent);
        r.aborted      = aborted;
        return r;
    endfunction

    // Statistics model, one category per frame
    task automatic count_rec(input eth_mon_pkg::frame_rec_t r);
        exp_stats.total_bytes += r.length_bytes;
        if (r.aborted) exp_stats.aborted_frames += 1;
        else if (r.error) exp_stats.error_frames += 1;
        else if (r.oversize) exp_stats.oversize_frames += 1;
        else if (r.runt) exp_stats.runt_frames += 1;
        else exp_stats.good_frames += 1;
    endtask

    // Hold one beat on the bus until valid and ready meet
    task automatic drive_beat(input eth_mon_pkg::beat_t b, input bit gaps);
        bit v;
        bit r;
        gen_beats++;
        do begin
            @(negedge clk);
            v = gaps ? ($urandom % 4 != 0) : 1'b1;
            r = gaps ? ($urandom % 4 != 0) : 1'b1;
            valid         = v;
            ready         = r;
            data          = b.data;
            empty         = b.empty;
            startofpacket = b.sop;
            endofpacket   = b.eop;
            error         = b.error;
        end while (!(v && r));
    endtask

    task automatic go_idle();
        @(negedge clk);
        valid = 1'b0;
        ready = 1'b0;
    endtask

    // cut above zero sends only that many beats and leaves the frame open
    // keep is the number of beats expected in the buffer, 0 for a dropped frame
    task automatic send_frame(input int nbytes, input int cut, input bit err,
        input int keep, input bit gaps);
        byte unsigned       bytes[$];
        eth_mon_pkg::beat_t b;
        eth_mon_pkg::beat_t e;
        int                 nbeats;
        int                 sent;
        int                 idx;
        for (int k = 0; k < nbytes; k++) bytes.push_back(8'($urandom));
        nbeats = (nbytes + 7) / 8;
        sent = (cut > 0) ? cut : nbeats;
        for (int i = 0; i < sent; i++) begin
            b = '0;
            for (int s = 0; s < `ETH_MON_NUM_SYMBOLS; s++) begin
                idx = i * `ETH_MON_NUM_SYMBOLS + s;
                // First byte goes to the most significant symbol
                b.data[`ETH_MON_DATA_W-1-`ETH_MON_SYMBOL_W*s -: `ETH_MON_SYMBOL_W] =
                    (idx < nbytes) ? bytes[idx] : 8'($urandom);
            end
            b.sop   = (i == 0);
            b.eop   = (cut == 0) && (i == sent - 1);
            b.empty = b.eop ? `ETH_MON_EMPTY_W'(nbeats * 8 - nbytes) : '0;
            b.error = b.eop && err;
            drive_beat(b, gaps);
            e = b;
            // Padding symbols carry no frame data
            if (b.eop) e.data = b.data & ({`ETH_MON_DATA_W{1'b1}} << (8 * b.empty));
            if (keep < 0 || i < keep) exp_beats.push_back(e);
        end
        go_idle();
        if (keep == 0) begin
            exp_stats.dropped_frames += 1;
        end else begin
            exp_recs.push_back(expect_rec((cut > 0) ? cut * 8 : nbytes, sent, keep, err, cut > 0));
            count_rec(exp_recs[$]);
        end
    endtask

    task automatic send_stray(input int n);
        eth_mon_pkg::beat_t b;
        for (int i = 0; i < n; i++) begin
            b = '0;
            b.data = {$urandom, $urandom};
            drive_beat(b, 1'b0);
            exp_stats.stray_beats += 1;
        end
        go_idle();
    endtask

    task automatic drain();
        while (exp_recs.size() != 0 || beats_left != 0) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    task automatic report_counts();
        $display("Checks %0d, record errors %0d, beat errors %0d, stats errors %0d, other errors %0d",
            checks, rec_errors, beat_errors, stat_errors, other_errors);
    endtask

    // Pops a record, then the beats it claims, comparing each with the model
    always @(negedge clk) begin : compare
        eth_mon_pkg::frame_rec_t r_exp;
        eth_mon_pkg::beat_t      b_exp;
        eth_mon_pkg::beat_t      got;
        rec_pop  = 1'b0;
        beat_pop = 1'b0;
        if (!reset && beats_left > 0 && beat_avail) begin
            got = beat_out;
            if (got.eop) got.data = got.data & ({`ETH_MON_DATA_W{1'b1}} << (8 * got.empty));
            b_exp = (exp_beats.size() != 0) ? exp_beats.pop_front() : '0;
            checks++;
            assert (got == b_exp) else begin
                beat_errors++;
                $display("Error: %s beat expected %h actual %h", test_name, b_exp, got);
            end
            beat_pop = 1'b1;
            beats_left--;
        end else if (!reset && beats_left == 0 && !hold && rec_avail) begin
            if (exp_recs.size() == 0) begin
                other_errors++;
                $display("A record came out for a frame that should have none");
                beats_left = rec_out.stored_beats;
            end else begin
                r_exp = exp_recs.pop_front();
                checks++;
                assert (rec_out == r_exp) else begin
                    rec_errors++;
                    $display("Error: %s record expected %h actual %h", test_name, r_exp, rec_out);
                end
                // Model decides how many beats belong to this record
                beats_left = r_exp.stored_beats;
            end
            rec_pop = 1'b1;
        end
    end

    // Time limit grows with every beat put on the bus
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= gen_beats * 4 + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped by the watchdog after %0d cycles in %s", cycles, test_name);
        report_counts();
        $display("Verification failed");
        $finish;
    end

    initial begin
        void'($urandom(70));
        reset = 1'b1;
        {startofpacket, endofpacket, valid, ready, error} = '0;
        data = '0;
        empty = '0;
        beat_pop = 1'b0;
        rec_pop = 1'b0;
        hold = 1'b0;
        beats_left = 0;
        exp_stats = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_name = "reset_state";
        @(negedge clk);
        assert (!rec_avail && !beat_avail) else begin
            other_errors++;
            $display("Readout flags are high right after reset");
        end
        assert (stats == '0) else begin
            stat_errors++;
            $display("Error: %s stats expected %h actual %h", test_name, '0, stats);
        end

        test_name = "random_good";
        repeat (12) send_frame(64 + $urandom % 193, 0, 1'b0, -1, 1'b1);
        drain();

        test_name = "flag_frames";
        send_frame(40, 0, 1'b0, -1, 1'b1);
        send_frame(300, 0, 1'b0, -1, 1'b1);
        send_frame(100, 0, 1'b1, -1, 1'b1);
        send_frame(30, 0, 1'b1, -1, 1'b1);
        drain();

        test_name = "abort_stray";
        send_frame(128, 3, 1'b0, -1, 1'b1);
        send_frame(96, 0, 1'b0, -1, 1'b1);
        send_stray(2);
        drain();

        // Buffer takes only its depth of an 80 beat frame
        test_name = "truncate";
        hold = 1'b1;
        send_frame(640, 0, 1'b0, `ETH_MON_BEAT_DEPTH, 1'b0);
        while (!rec_avail) @(negedge clk);
        hold = 1'b0;
        drain();

        // Record queue holds eight, the ninth frame finds no room
        test_name = "record_full";
        hold = 1'b1;
        for (int i = 0; i < 9; i++) send_frame(64, 0, 1'b0, (i < 8) ? -1 : 0, 1'b1);
        hold = 1'b0;
        drain();

        test_name = "final_stats";
        assert (!rec_avail && !beat_avail && exp_beats.size() == 0) else begin
            other_errors++;
            $display("Readout does not match the frames sent, data left over");
        end
        assert (stats == exp_stats) else begin
            stat_errors++;
            $display("Error: %s stats expected %h actual %h", test_name, exp_stats, stats);
        end
        report_counts();
        if (rec_errors + beat_errors + stat_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
